// ==== source/core_pkg.sv ====
// ------------------------------
// core package
// widths, opcodes and the control
// enumerations shared by the scalar core
// ------------------------------
package core_pkg;

    localparam int xlen       = 32;
    localparam int addr_width = 16;
    localparam int reset_pc   = 0;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [addr_width-1:0] addr_t;
    typedef logic [4:0]            reg_idx_t;

    // major opcodes of the supported subset
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_system = 7'b1110011;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor
    } alu_op_t;

    typedef enum logic [1:0] {
        br_none,
        br_eq,
        br_ne,
        br_jump
    } branch_t;

    // source of the register write value
    typedef enum logic [1:0] {
        wb_none,
        wb_alu,
        wb_load,
        wb_link
    } wb_sel_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback,
        st_halt
    } step_t;

endpackage

// ==== source/instr_decoder.sv ====
// ------------------------------
// instruction decoder
// splits the held instruction into register
// indices, sign-extended immediate and control
// ------------------------------
module instr_decoder (
    input  core_pkg::word_t    instr,
    output core_pkg::reg_idx_t rs1,
    output core_pkg::reg_idx_t rs2,
    output core_pkg::reg_idx_t rd,
    output core_pkg::word_t    imm,
    output core_pkg::alu_op_t  alu_op,
    output logic               use_imm,
    output core_pkg::branch_t  branch,
    output core_pkg::wb_sel_t  wb_sel,
    output logic               is_load,
    output logic               is_store,
    output logic               is_halt
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    // immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        imm      = imm_i;
        alu_op   = alu_add;
        use_imm  = 1'b0;
        branch   = br_none;
        wb_sel   = wb_none;
        is_load  = 1'b0;
        is_store = 1'b0;
        is_halt  = 1'b0;
        case (opcode)
            op_imm, op_reg: begin
                use_imm = (opcode == op_imm);
                wb_sel  = wb_alu;
                case (funct3)
                    3'b000: begin
                        // sub only exists in the register form
                        if (opcode == op_reg && instr[30]) begin
                            alu_op = alu_sub;
                        end
                    end
                    3'b100: alu_op = alu_xor;
                    3'b110: alu_op = alu_or;
                    3'b111: alu_op = alu_and;
                    default: wb_sel = wb_none;
                endcase
            end
            op_load: begin
                use_imm = 1'b1;
                is_load = 1'b1;
                wb_sel  = wb_load;
            end
            op_store: begin
                imm      = imm_s;
                use_imm  = 1'b1;
                is_store = 1'b1;
            end
            op_branch: begin
                imm = imm_b;
                if (funct3 == 3'b000) begin
                    branch = br_eq;
                end else if (funct3 == 3'b001) begin
                    branch = br_ne;
                end
            end
            op_jal: begin
                imm    = imm_j;
                branch = br_jump;
                wb_sel = wb_link;
            end
            // ebreak, everything else in system space is a nop
            op_system: is_halt = (instr[31:20] == 12'h001) && (instr[19:7] == '0);
            default: ;
        endcase
    end

endmodule

// ==== source/reg_file.sv ====
// ------------------------------
// scalar register file
// 32 x 32 bit, two async reads, one write
// x0 reads as zero
// ------------------------------
module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  core_pkg::reg_idx_t rs1,
    input  core_pkg::reg_idx_t rs2,
    input  core_pkg::reg_idx_t rd,
    input  core_pkg::word_t    rd_data,
    input  logic               rd_we,
    output core_pkg::word_t    rs1_data,
    output core_pkg::word_t    rs2_data
);
    import core_pkg::*;

    // x1 .. x31 only
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd != '0) begin
            regs[rd] <= rd_data;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== source/scalar_alu.sv ====
// ------------------------------
// scalar alu
// arithmetic and logic result, branch
// decision, next pc and link value
// ------------------------------
module scalar_alu (
    input  core_pkg::word_t   rs1_data,
    input  core_pkg::word_t   rs2_data,
    input  core_pkg::word_t   imm,
    input  core_pkg::word_t   pc,
    input  core_pkg::alu_op_t alu_op,
    input  logic              use_imm,
    input  core_pkg::branch_t branch,
    output core_pkg::word_t   alu_result,
    output core_pkg::word_t   next_pc,
    output core_pkg::word_t   link
);
    import core_pkg::*;

    word_t operand_b;
    logic  equal;
    logic  taken;

    assign operand_b = use_imm ? imm : rs2_data;

    always_comb begin
        case (alu_op)
            alu_add: alu_result = rs1_data + operand_b;
            alu_sub: alu_result = rs1_data - operand_b;
            alu_and: alu_result = rs1_data & operand_b;
            alu_or:  alu_result = rs1_data | operand_b;
            alu_xor: alu_result = rs1_data ^ operand_b;
            default: alu_result = '0;
        endcase
    end

    // branch compare always on the two registers
    assign equal = (rs1_data == rs2_data);

    always_comb begin
        case (branch)
            br_eq:   taken = equal;
            br_ne:   taken = !equal;
            br_jump: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign link    = pc + 32'd4;
    assign next_pc = taken ? pc + imm : link;

endmodule

// ==== source/result_select.sv ====
// ------------------------------
// result stage
// holds load data and picks the
// register write value and enable
// ------------------------------
module result_select (
    input  logic              clk,
    input  logic              rst,
    input  core_pkg::step_t   step,
    input  logic              wb_ack,
    input  core_pkg::word_t   wb_dat_r,
    input  core_pkg::wb_sel_t wb_sel,
    input  core_pkg::word_t   alu_result,
    input  core_pkg::word_t   link,
    output core_pkg::word_t   rd_data,
    output logic              rd_we
);
    import core_pkg::*;

    word_t load_data;

    // data ack of a load ends the memory step
    always_ff @(posedge clk) begin
        if (!rst) begin
            load_data <= '0;
        end else if (step == st_memory && wb_ack && wb_sel == wb_load) begin
            load_data <= wb_dat_r;
        end
    end

    always_comb begin
        case (wb_sel)
            wb_alu:  rd_data = alu_result;
            wb_load: rd_data = load_data;
            wb_link: rd_data = link;
            default: rd_data = '0;
        endcase
    end

    assign rd_we = (step == st_writeback) && (wb_sel != wb_none);

endmodule

// ==== source/core_sequencer.sv ====
// ------------------------------
// core sequencer
// steps each instruction through fetch,
// decode, execute, memory and write-back,
// owns pc, instruction register and the
// wishbone master port
// ------------------------------
module core_sequencer (
    input  logic            clk,
    input  logic            rst,
    input  logic            wb_ack,
    input  core_pkg::word_t wb_dat_r,
    input  core_pkg::word_t next_pc,
    input  logic            is_load,
    input  logic            is_store,
    input  logic            is_halt,
    input  core_pkg::word_t store_data,
    input  core_pkg::word_t alu_result,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic            wb_we,
    output core_pkg::addr_t wb_adr,
    output core_pkg::word_t wb_dat_w,
    output core_pkg::word_t instr,
    output core_pkg::word_t pc,
    output core_pkg::step_t step,
    output logic            halted
);
    import core_pkg::*;

    // ------------------------------
    // step machine and bus master
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            step   <= st_fetch;
            pc     <= word_t'(reset_pc);
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
        end else begin
            case (step)
                st_fetch: begin
                    if (!wb_stb) begin
                        // first request out of reset
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we  <= 1'b0;
                        wb_adr <= pc[addr_width-1:0];
                    end else if (wb_ack) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        instr  <= wb_dat_r;
                        step   <= st_decode;
                    end
                end
                st_decode: step <= st_execute;
                st_execute: begin
                    if (is_halt) begin
                        step <= st_halt;
                    end else if (is_load || is_store) begin
                        wb_cyc   <= 1'b1;
                        wb_stb   <= 1'b1;
                        wb_we    <= is_store;
                        wb_adr   <= alu_result[addr_width-1:0];
                        wb_dat_w <= store_data;
                        step     <= st_memory;
                    end else begin
                        step <= st_writeback;
                    end
                end
                st_memory: begin
                    if (wb_ack) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        wb_we  <= 1'b0;
                        step   <= st_writeback;
                    end
                end
                st_writeback: begin
                    // next fetch goes out right away
                    pc     <= next_pc;
                    wb_cyc <= 1'b1;
                    wb_stb <= 1'b1;
                    wb_we  <= 1'b0;
                    wb_adr <= next_pc[addr_width-1:0];
                    step   <= st_fetch;
                end
                default: step <= st_halt;
            endcase
        end
    end

    assign halted = (step == st_halt);

endmodule

// ==== source/scalar_core.sv ====
// ------------------------------
// scalar core top level
// rv32 subset core with one wishbone
// classic master for fetch and data
// ------------------------------
module scalar_core (
    input  logic            clk,
    input  logic            rst,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic            wb_we,
    output core_pkg::addr_t wb_adr,
    output core_pkg::word_t wb_dat_w,
    input  core_pkg::word_t wb_dat_r,
    input  logic            wb_ack,
    output logic            halted
);
    import core_pkg::*;

    word_t    instr;
    word_t    pc;
    step_t    step;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm;
    alu_op_t  alu_op;
    logic     use_imm;
    branch_t  branch;
    wb_sel_t  wb_sel;
    logic     is_load;
    logic     is_store;
    logic     is_halt;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    alu_result;
    word_t    next_pc;
    word_t    link;
    word_t    rd_data;
    logic     rd_we;

    core_sequencer i_core_sequencer (
        .clk        (clk),
        .rst        (rst),
        .wb_ack     (wb_ack),
        .wb_dat_r   (wb_dat_r),
        .next_pc    (next_pc),
        .is_load    (is_load),
        .is_store   (is_store),
        .is_halt    (is_halt),
        .store_data (rs2_data),
        .alu_result (alu_result),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .instr      (instr),
        .pc         (pc),
        .step       (step),
        .halted     (halted)
    );

    instr_decoder i_instr_decoder (
        .instr    (instr),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .imm      (imm),
        .alu_op   (alu_op),
        .use_imm  (use_imm),
        .branch   (branch),
        .wb_sel   (wb_sel),
        .is_load  (is_load),
        .is_store (is_store),
        .is_halt  (is_halt)
    );

    reg_file i_reg_file (
        .clk      (clk),
        .rst      (rst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .rd_data  (rd_data),
        .rd_we    (rd_we),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    scalar_alu i_scalar_alu (
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .pc         (pc),
        .alu_op     (alu_op),
        .use_imm    (use_imm),
        .branch     (branch),
        .alu_result (alu_result),
        .next_pc    (next_pc),
        .link       (link)
    );

    result_select i_result_select (
        .clk        (clk),
        .rst        (rst),
        .step       (step),
        .wb_ack     (wb_ack),
        .wb_dat_r   (wb_dat_r),
        .wb_sel     (wb_sel),
        .alu_result (alu_result),
        .link       (link),
        .rd_data    (rd_data),
        .rd_we      (rd_we)
    );

endmodule

// ==== testbench/tb_clock.sv ====
// ------------------------------
// testbench clock
// free-running clk, 20 ns period
// ------------------------------
module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial clk = 1'b0;

    // half period of 10 ns
    always #10 clk = ~clk;

endmodule

// ==== testbench/scalar_core_asserts.sv ====
// ------------------------------
// wishbone master assertions
// bound to the core sequencer
// ------------------------------
module scalar_core_asserts (
    input logic            clk,
    input logic            rst,
    input logic            wb_cyc,
    input logic            wb_stb,
    input logic            wb_we,
    input core_pkg::addr_t wb_adr,
    input core_pkg::word_t wb_dat_w,
    input logic            wb_ack,
    input core_pkg::step_t step
);
    timeunit 1ns;
    timeprecision 1ps;
    import core_pkg::*;

    int failures = 0;

    stb_needs_cyc: assert property (@(posedge clk) disable iff (!rst) wb_stb |-> wb_cyc)
        else begin
            failures = failures + 1;
            $error("wb_stb high while wb_cyc is low");
        end

    // cyc, stb and every request field hold until ack
    request_stable: assert property (@(posedge clk) disable iff (!rst)
        (wb_stb && !wb_ack) |=> (wb_cyc && wb_stb && $stable(wb_adr) && $stable(wb_we)
                                 && $stable(wb_dat_w)))
        else begin
            failures = failures + 1;
            $error("request changed before ack");
        end

    idle_when_halted: assert property (@(posedge clk) disable iff (!rst)
        (step == st_halt) |-> (!wb_cyc && !wb_stb))
        else begin
            failures = failures + 1;
            $error("bus cycle while halted");
        end

endmodule

// ==== testbench/scalar_core_tb.sv ====
// ------------------------------
// scalar core testbench
// program image, wishbone slave with
// random ack delay, reference model,
// store and read checks, watchdog
// ------------------------------
module scalar_core_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import core_pkg::*;

    localparam int    mem_words    = 512;
    localparam int    worst_cycles = 16;
    localparam word_t ebreak       = 32'h0010_0073;

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    addr_t       wb_adr;
    word_t       wb_dat_w;
    word_t       wb_dat_r    = '0;
    logic        wb_ack      = 1'b0;
    logic        halted;
    word_t       mem [mem_words];
    addr_t       exp_adr [$];
    word_t       exp_dat [$];
    addr_t       exp_read [$];
    int          limit_cycles = 0;
    logic [15:0] lfsr         = 16'd49;
    logic [1:0]  ack_wait     = 2'd0;
    logic        ack_pending  = 1'b0;

    tb_clock i_tb_clock (.clk(clk));

    scalar_core i_scalar_core (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .halted   (halted)
    );

    bind core_sequencer scalar_core_asserts i_sequencer_asserts (
        .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_ack(wb_ack), .step(step)
    );

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic addr_check(input string name, input addr_t exp, input addr_t got);
        if (got !== exp) begin
            stop_on_failure($sformatf("Mismatch %s: expected 0x%h, got 0x%h", name, exp, got));
        end
    endtask

    task automatic word_check(input string name, input word_t exp, input word_t got);
        if (got !== exp) begin
            stop_on_failure($sformatf("Mismatch %s: expected 0x%h, got 0x%h", name, exp, got));
        end
    endtask

    task automatic bit_check(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            stop_on_failure($sformatf("Mismatch %s: expected 0x%h, got 0x%h", name, exp, got));
        end
    endtask

    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // instruction encoders
    function automatic word_t itype(input logic [6:0] opc, input logic [2:0] f3,
                                    input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic word_t rtype(input logic [6:0] f7, input logic [2:0] f3,
                                    input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op_reg};
    endfunction

    function automatic word_t stype(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], op_store};
    endfunction

    function automatic word_t btype(input logic [2:0] f3, input int rs1, input int rs2,
                                    input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic word_t jtype(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], op_jal};
    endfunction

    // pattern over the whole word index
    task automatic fill_memory();
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = {16'hc0de ^ 16'(i), 16'(i)};
        end
    endtask

    task automatic load_program();
        word_t prog [$];
        prog = {
            itype(op_imm, 3'b000, 1, 0, 100),       // x1 = 100
            itype(op_imm, 3'b000, 2, 0, -7),        // x2 = -7
            rtype(7'h00, 3'b000, 3, 1, 2),          // add
            rtype(7'h20, 3'b000, 4, 2, 1),          // sub
            rtype(7'h00, 3'b111, 5, 1, 2),          // and
            rtype(7'h00, 3'b110, 6, 1, 2),          // or
            rtype(7'h00, 3'b100, 7, 1, 2),          // xor
            itype(op_imm, 3'b000, 10, 0, 1024),     // data base 0x400
            stype(3, 10, 0),
            stype(4, 10, 4),
            stype(5, 10, 8),
            stype(6, 10, 12),
            stype(7, 10, 16),
            itype(op_imm, 3'b000, 0, 0, 55),        // lost write to x0
            stype(0, 10, 20),
            itype(op_load, 3'b010, 8, 10, 4),       // load back the sub result
            stype(8, 10, 24),
            btype(3'b000, 1, 2, 8),                 // beq not taken
            itype(op_imm, 3'b000, 9, 0, 1),
            btype(3'b001, 1, 2, 8),                 // bne taken
            itype(op_imm, 3'b000, 9, 9, 16),
            btype(3'b000, 3, 3, 8),                 // beq taken
            itype(op_imm, 3'b000, 9, 9, 32),
            btype(3'b001, 1, 1, 8),                 // bne not taken
            itype(op_imm, 3'b000, 9, 9, 2),
            jtype(11, 8),                           // jal with link 104
            itype(op_imm, 3'b000, 9, 9, 64),
            stype(9, 10, 28),
            stype(11, 10, -4),
            ebreak
        };
        foreach (prog[i]) begin
            mem[i] = prog[i];
        end
    endtask

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic int run_reference();
        word_t regs [32];
        word_t dmem [mem_words];
        word_t pc;
        word_t next;
        word_t ins;
        word_t a;
        word_t b;
        word_t ea;
        logic  done;
        int    count;
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        dmem  = mem;
        pc    = word_t'(reset_pc);
        done  = 1'b0;
        count = 0;
        while (!done && count < 4096) begin
            ins = dmem[pc[10:2]];
            exp_read.push_back(pc[addr_width-1:0]);
            count++;
            a    = regs[ins[19:15]];
            b    = regs[ins[24:20]];
            next = pc + 32'd4;
            case (ins[6:0])
                op_imm, op_reg: begin
                    if (ins[6:0] == op_imm) begin
                        b = {{20{ins[31]}}, ins[31:20]};
                    end
                    case (ins[14:12])
                        3'b000: regs[ins[11:7]] = (ins[6:0] == op_reg && ins[30]) ? a - b : a + b;
                        3'b100: regs[ins[11:7]] = a ^ b;
                        3'b110: regs[ins[11:7]] = a | b;
                        default: regs[ins[11:7]] = a & b;
                    endcase
                end
                op_load: begin
                    ea = a + {{20{ins[31]}}, ins[31:20]};
                    exp_read.push_back(ea[addr_width-1:0]);
                    regs[ins[11:7]] = dmem[ea[10:2]];
                end
                op_store: begin
                    ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    exp_adr.push_back(ea[addr_width-1:0]);
                    exp_dat.push_back(b);
                    dmem[ea[10:2]] = b;
                end
                op_branch: begin
                    if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b)) begin
                        next = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                op_jal: begin
                    regs[ins[11:7]] = pc + 32'd4;
                    next = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                op_system: done = (ins == ebreak);
                default: ;
            endcase
            regs[0] = '0;
            pc      = next;
        end
        return count;
    endfunction

    // ------------------------------
    // wishbone slave with 0 to 3 wait cycles
    // ------------------------------
    always @(negedge clk) begin
        if (!rst) begin
            wb_ack      = 1'b0;
            ack_pending = 1'b0;
        end else if (wb_ack) begin
            // single-cycle ack so the master drops stb next
            wb_ack = 1'b0;
        end else if (wb_stb) begin
            if (!ack_pending) begin
                lfsr        = lfsr_next(lfsr);
                ack_wait[1] = lfsr[0];
                lfsr        = lfsr_next(lfsr);
                ack_wait[0] = lfsr[0];
                ack_pending = 1'b1;
            end
            if (ack_wait == 2'd0) begin
                if (wb_we) begin
                    mem[wb_adr[10:2]] = wb_dat_w;
                end else begin
                    wb_dat_r = mem[wb_adr[10:2]];
                end
                wb_ack      = 1'b1;
                ack_pending = 1'b0;
            end else begin
                ack_wait = ack_wait - 2'd1;
            end
        end
    end

    // compare each acked transfer with the reference
    always @(posedge clk) begin
        if (rst && wb_stb && wb_ack) begin
            if (wb_we && exp_adr.size() == 0) begin
                stop_on_failure("store cycle seen after the last expected store");
            end else if (wb_we) begin
                addr_check("wb_adr", exp_adr.pop_front(), wb_adr);
                word_check("wb_dat_w", exp_dat.pop_front(), wb_dat_w);
            end else if (exp_read.size() == 0) begin
                stop_on_failure("read cycle seen after the last expected read");
            end else begin
                addr_check("wb_adr", exp_read.pop_front(), wb_adr);
            end
        end
    end

    always @(negedge clk) begin
        if (i_scalar_core.i_core_sequencer.i_sequencer_asserts.failures != 0) begin
            stop_on_failure("a Wishbone protocol assertion failed");
        end
    end

    // watchdog
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        stop_on_failure($sformatf("Timeout: core did not halt within %0d cycles", limit_cycles));
    end

    initial begin
        rst = 1'b0;
        fill_memory();
        load_program();
        limit_cycles = run_reference() * worst_cycles + 64;
        repeat (4) @(posedge clk);
        @(negedge clk);
        bit_check("wb_cyc", 1'b0, wb_cyc);
        bit_check("wb_stb", 1'b0, wb_stb);
        bit_check("wb_we", 1'b0, wb_we);
        bit_check("halted", 1'b0, halted);
        rst = 1'b1;
        // first fetch one cycle after release
        @(negedge clk);
        bit_check("wb_cyc", 1'b1, wb_cyc);
        bit_check("wb_stb", 1'b1, wb_stb);
        bit_check("wb_we", 1'b0, wb_we);
        addr_check("wb_adr", addr_t'(reset_pc), wb_adr);
        while (!halted) @(negedge clk);
        repeat (8) begin
            @(negedge clk);
            bit_check("wb_cyc", 1'b0, wb_cyc);
            bit_check("wb_stb", 1'b0, wb_stb);
        end
        if (exp_adr.size() != 0 || exp_read.size() != 0) begin
            stop_on_failure($sformatf("halted with %0d stores and %0d reads still expected",
                                      exp_adr.size(), exp_read.size()));
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

// ==== scalar_core.f ====
source/core_pkg.sv
source/instr_decoder.sv
source/reg_file.sv
source/scalar_alu.sv
source/result_select.sv
source/core_sequencer.sv
source/scalar_core.sv
testbench/tb_clock.sv
testbench/scalar_core_asserts.sv
testbench/scalar_core_tb.sv

// ==== Makefile ====
# Verilator build and run for the scalar core testbench

VERILATOR ?= verilator
TOP       ?= scalar_core_tb
FILELIST  ?= scalar_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= Simulation passed
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
